//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -Wno-fatal
TOP       = tb_posit_accum
FILELIST  = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Result: FAILED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hdl/posit_accum.sv
// Posit accumulator top level. Each start adds in_word to the running sum,
// the rounded sum appears on result with a one-cycle done strobe.
`timescale 1ns/10ps

module posit_accum
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  logic [posit_pkg::NBITS-1:0] in_word,
    output logic [posit_pkg::NBITS-1:0] result,
    output logic                        done,
    output logic                        zero,
    output logic                        inf
);
    import posit_pkg::*;

    logic [NBITS-1:0] in_q;      // Input register
    logic             in_valid;
    logic [NBITS-1:0] acc_q;     // Running sum as a posit word

    // Decoder outputs
    logic                      in_sign, in_zero, in_nar;
    logic signed [SCALE_W-1:0] in_scale;
    logic [FRAC_W-1:0]         in_frac;
    logic                      acc_sign, acc_zero, acc_nar;
    logic signed [SCALE_W-1:0] acc_scale;
    logic [FRAC_W-1:0]         acc_frac;

    // Registered decoded operands
    logic                      dec_valid;
    logic                      a_sign, a_zero, a_nar;
    logic                      b_sign, b_zero, b_nar;
    logic signed [SCALE_W-1:0] a_scale, b_scale;
    logic [FRAC_W-1:0]         a_frac, b_frac;

    logic                      sum_valid, sum_sign, sum_sticky, sum_zero, sum_nar;
    logic [FRAC_W+1:0]         sum_raw;
    logic signed [SCALE_W-1:0] sum_scale;
    logic                      norm_valid, norm_sign, norm_sticky, norm_zero, norm_nar;
    logic [FRAC_W+1:0]         norm_frac;
    logic signed [SCALE_W-1:0] norm_scale;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            in_valid  <= 1'b0;
            dec_valid <= 1'b0;
            acc_q     <= '0;  // Posit zero
        end
        else
        begin
            in_valid  <= start;
            dec_valid <= in_valid;
            if (done)
                acc_q <= result;  // Feedback for the next start
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
            in_q <= in_word;
        a_sign  <= in_sign;
        a_scale <= in_scale;
        a_frac  <= in_frac;
        a_zero  <= in_zero;
        a_nar   <= in_nar;
        b_sign  <= acc_sign;
        b_scale <= acc_scale;
        b_frac  <= acc_frac;
        b_zero  <= acc_zero;
        b_nar   <= acc_nar;
    end

    posit_decode u_dec_in
    (
        .word     (in_q),
        .sign     (in_sign),
        .scale    (in_scale),
        .fraction (in_frac),
        .is_zero  (in_zero),
        .is_nar   (in_nar)
    );

    posit_decode u_dec_acc
    (
        .word     (acc_q),
        .sign     (acc_sign),
        .scale    (acc_scale),
        .fraction (acc_frac),
        .is_zero  (acc_zero),
        .is_nar   (acc_nar)
    );

    posit_align_add u_align_add
    (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (dec_valid),
        .a_sign     (a_sign),
        .a_scale    (a_scale),
        .a_fraction (a_frac),
        .a_zero     (a_zero),
        .a_nar      (a_nar),
        .b_sign     (b_sign),
        .b_scale    (b_scale),
        .b_fraction (b_frac),
        .b_zero     (b_zero),
        .b_nar      (b_nar),
        .sum_valid  (sum_valid),
        .sum_raw    (sum_raw),
        .sum_scale  (sum_scale),
        .sum_sign   (sum_sign),
        .sticky     (sum_sticky),
        .sum_zero   (sum_zero),
        .sum_nar    (sum_nar)
    );

    posit_normalize u_normalize
    (
        .clk         (clk),
        .rst         (rst),
        .sum_valid   (sum_valid),
        .sum_raw     (sum_raw),
        .sum_scale   (sum_scale),
        .sum_sign    (sum_sign),
        .sum_sticky  (sum_sticky),
        .sum_zero    (sum_zero),
        .sum_nar     (sum_nar),
        .norm_valid  (norm_valid),
        .norm_frac   (norm_frac),
        .norm_scale  (norm_scale),
        .norm_sign   (norm_sign),
        .norm_sticky (norm_sticky),
        .norm_zero   (norm_zero),
        .norm_nar    (norm_nar)
    );

    posit_round_pack u_round_pack
    (
        .clk         (clk),
        .rst         (rst),
        .norm_valid  (norm_valid),
        .norm_frac   (norm_frac),
        .norm_scale  (norm_scale),
        .norm_sign   (norm_sign),
        .norm_sticky (norm_sticky),
        .norm_zero   (norm_zero),
        .norm_nar    (norm_nar),
        .result      (result),
        .done        (done),
        .zero        (zero),
        .inf         (inf)
    );

endmodule

//--- hdl/posit_align_add.sv
// Orders two decoded posits by magnitude, aligns the smaller one and adds or
// subtracts the significands over three registered steps.
`timescale 1ns/10ps

module posit_align_add
(
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 in_valid,
    input  logic                                 a_sign,
    input  logic signed [posit_pkg::SCALE_W-1:0] a_scale,
    input  logic [posit_pkg::FRAC_W-1:0]         a_fraction,
    input  logic                                 a_zero,
    input  logic                                 a_nar,
    input  logic                                 b_sign,
    input  logic signed [posit_pkg::SCALE_W-1:0] b_scale,
    input  logic [posit_pkg::FRAC_W-1:0]         b_fraction,
    input  logic                                 b_zero,
    input  logic                                 b_nar,
    output logic                                 sum_valid,
    output logic [posit_pkg::FRAC_W+1:0]         sum_raw,
    output logic signed [posit_pkg::SCALE_W-1:0] sum_scale,
    output logic                                 sum_sign,
    output logic                                 sticky,
    output logic                                 sum_zero,
    output logic                                 sum_nar
);
    import posit_pkg::*;

    localparam int SIG_W   = FRAC_W + 1;      // Significand with hidden bit
    localparam int GUARD_W = ALIGN_W - SIG_W; // Guard bits under the larger operand

    logic [SIG_W-1:0]   a_sig, b_sig;
    logic               a_first;            // a has the larger magnitude

    logic                      s2_valid, s3_valid;
    add_op_e                   s2_op, s3_op;
    logic                      s2_sign, s2_zero, s2_nar;
    logic                      s3_sign, s3_zero, s3_nar, s3_sticky;
    logic signed [SCALE_W-1:0] s2_scale, s3_scale;
    logic [SIG_W-1:0]          s2_hi, s2_lo, s3_hi;
    logic [SCALE_W-1:0]        s2_diff;     // Scale gap, never negative
    logic [ALIGN_W-1:0]        s3_lo;       // Aligned smaller significand

    logic [2*ALIGN_W-1:0]      lo_wide;
    logic [ALIGN_W:0]          total;
    logic [1:0]                lift;
    logic [ALIGN_W+2:0]        lifted;

    assign a_sig = {~(a_zero | a_nar), a_fraction};
    assign b_sig = {~(b_zero | b_nar), b_fraction};

    // Offset-binary scale then fraction, so equal scales still order correctly
    assign a_first = {~a_scale[SCALE_W-1], a_scale[SCALE_W-2:0], a_fraction} >=
                     {~b_scale[SCALE_W-1], b_scale[SCALE_W-2:0], b_fraction};

    // Smaller significand at the top, bits that fall off go to the lower half
    assign lo_wide = {s2_lo, {(2*ALIGN_W-SIG_W){1'b0}}} >> s2_diff;

    assign total = (s3_op == OP_ADD) ? {1'b0, s3_hi, {GUARD_W{1'b0}}} + {1'b0, s3_lo}
                                     : {1'b0, s3_hi, {GUARD_W{1'b0}}} - {1'b0, s3_lo};

    // Window placement; cancellation past two bits only happens when it is exact
    assign lift   = total[ALIGN_W] ? 2'd0 : (total[ALIGN_W-1] ? 2'd1 : 2'd2);
    assign lifted = {total, 2'b00} << lift;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            s2_valid  <= 1'b0;
            s3_valid  <= 1'b0;
            sum_valid <= 1'b0;
        end
        else
        begin
            s2_valid  <= in_valid;
            s3_valid  <= s2_valid;
            sum_valid <= s3_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        // Ordered operands
        s2_op    <= (a_sign == b_sign) ? OP_ADD : OP_SUB;
        s2_sign  <= a_first ? a_sign : b_sign;
        s2_scale <= a_first ? a_scale : b_scale;
        s2_hi    <= a_first ? a_sig : b_sig;
        s2_lo    <= a_first ? b_sig : a_sig;
        s2_diff  <= a_first ? a_scale - b_scale : b_scale - a_scale;
        s2_zero  <= a_zero & b_zero;
        s2_nar   <= a_nar | b_nar;

        // Alignment shift, saturated at the full width
        s3_op    <= s2_op;
        s3_sign  <= s2_sign;
        s3_scale <= s2_scale;
        s3_hi    <= s2_hi;
        s3_zero  <= s2_zero;
        s3_nar   <= s2_nar;
        if (s2_diff >= ALIGN_W)
        begin
            s3_lo     <= '0;
            s3_sticky <= |s2_lo;
        end
        else
        begin
            s3_lo     <= lo_wide[2*ALIGN_W-1 -: ALIGN_W];
            s3_sticky <= |lo_wide[ALIGN_W-1:0];
        end

        // Sum with its top bits kept and the rest folded into sticky
        sum_raw   <= lifted[ALIGN_W+2 -: FRAC_W+2];
        sticky    <= s3_sticky | (|lifted[ALIGN_W-FRAC_W:0]);
        sum_scale <= s3_scale + SCALE_W'(1) - SCALE_W'(lift);
        sum_sign  <= s3_sign;  // Sign of the larger operand
        sum_zero  <= s3_zero;
        sum_nar   <= s3_nar;
    end

endmodule

//--- hdl/posit_decode.sv
// Unpacks one posit word into sign, scale and left-aligned fraction.
// Purely combinational, used on both accumulator operands.
`timescale 1ns/10ps

module posit_decode
(
    input  logic [posit_pkg::NBITS-1:0]          word,
    output logic                                 sign,
    output logic signed [posit_pkg::SCALE_W-1:0] scale,
    output logic [posit_pkg::FRAC_W-1:0]         fraction,
    output logic                                 is_zero,
    output logic                                 is_nar
);
    import posit_pkg::*;

    logic [NBITS-1:0]          mag;     // Absolute value of the word
    logic [NBITS-2:0]          body;
    logic [NBITS-2:0]          rest;    // Exponent and fraction, left-aligned
    logic [5:0]                run;     // Length of the regime run
    logic                      run_open;
    logic signed [SCALE_W-1:0] regime;

    assign sign    = word[NBITS-1];
    assign is_zero = (word == '0);
    assign is_nar  = (word == {1'b1, {(NBITS-1){1'b0}}});
    assign mag     = sign ? -word : word;
    assign body    = mag[NBITS-2:0];

    // Count bits equal to the first regime bit
    always_comb
    begin
        run      = '0;
        run_open = 1'b1;
        for (int i = NBITS - 2; i >= 0; i--)
        begin
            if (run_open && body[i] == body[NBITS-2])
                run = run + 1'b1;
            else
                run_open = 1'b0;
        end
    end

    // Run of ones gives k = run-1, run of zeros gives k = -run
    assign regime = body[NBITS-2] ? $signed({{(SCALE_W-6){1'b0}}, run}) - 1
                                  : -$signed({{(SCALE_W-6){1'b0}}, run});

    assign rest = body << (run + 6'd1);  // Drop regime and terminator

    assign scale = (regime <<< ES) + $signed({{(SCALE_W-ES){1'b0}}, rest[NBITS-2 -: ES]});

    assign fraction = rest[NBITS-2-ES -: FRAC_W];

endmodule

//--- hdl/posit_normalize.sv
// Normalizes the raw sum so that its leading one sits at the top,
// correcting the scale by the shift. One register stage.
`timescale 1ns/10ps

module posit_normalize
(
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 sum_valid,
    input  logic [posit_pkg::FRAC_W+1:0]         sum_raw,
    input  logic signed [posit_pkg::SCALE_W-1:0] sum_scale,
    input  logic                                 sum_sign,
    input  logic                                 sum_sticky,
    input  logic                                 sum_zero,
    input  logic                                 sum_nar,
    output logic                                 norm_valid,
    output logic [posit_pkg::FRAC_W+1:0]         norm_frac,
    output logic signed [posit_pkg::SCALE_W-1:0] norm_scale,
    output logic                                 norm_sign,
    output logic                                 norm_sticky,
    output logic                                 norm_zero,
    output logic                                 norm_nar
);
    import posit_pkg::*;

    logic [4:0]              lead_zeros;
    logic                    seen_one;
    logic signed [SCALE_W:0] scale_wide;  // One spare bit for deep cancellation

    // Leading zero count over the raw sum
    always_comb
    begin
        lead_zeros = '0;
        seen_one   = 1'b0;
        for (int i = FRAC_W + 1; i >= 0; i--)
        begin
            if (sum_raw[i])
                seen_one = 1'b1;
            else if (!seen_one)
                lead_zeros = lead_zeros + 1'b1;
        end
    end

    assign scale_wide = $signed({sum_scale[SCALE_W-1], sum_scale}) -
                        $signed({{(SCALE_W-4){1'b0}}, lead_zeros});

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            norm_valid <= 1'b0;
        else
            norm_valid <= sum_valid;
    end

    always_ff @(posedge clk)
    begin
        norm_frac   <= sum_raw << lead_zeros;
        norm_sign   <= sum_sign;
        norm_sticky <= sum_sticky;
        norm_zero   <= sum_zero | ~(|sum_raw);  // Exact cancellation
        norm_nar    <= sum_nar;
        // Clamp at the most negative scale, round_pack maps it to minpos anyway
        if (scale_wide[SCALE_W] != scale_wide[SCALE_W-1])
            norm_scale <= {1'b1, {(SCALE_W-1){1'b0}}};
        else
            norm_scale <= scale_wide[SCALE_W-1:0];
    end

endmodule

//--- hdl/posit_pkg.sv
// Posit format and pipeline constants shared by the accumulator RTL and its checker
// Compile this package before any module that imports it

package posit_pkg;

    localparam int NBITS     = 32;  // Posit word width
    localparam int ES        = 2;   // Exponent bits
    localparam int SCALE_W   = 8;   // Signed scale width
    localparam int FRAC_W    = 27;  // Stored fraction bits, hidden bit excluded
    localparam int ALIGN_W   = 64;  // Aligned significand with guard bits
    localparam int LATENCY   = 6;   // Edges from sampled start to done
    localparam int START_GAP = 7;   // Minimum edges between two starts

    // Scale of maxpos; the magnitude never goes beyond it
    localparam int MAX_SCALE = (NBITS - 2) * (1 << ES);

    // Magnitude operation, picked from the operand signs
    typedef enum logic
    {
        OP_ADD = 1'b0,  // Equal signs
        OP_SUB = 1'b1   // Unequal signs
    } add_op_e;

endpackage

//--- hdl/posit_round_pack.sv
// Packs the normalized sum into regime, exponent and fraction, rounds to
// nearest even and applies the sign. Its registers are the accumulator outputs.
`timescale 1ns/10ps

module posit_round_pack
(
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 norm_valid,
    input  logic [posit_pkg::FRAC_W+1:0]         norm_frac,
    input  logic signed [posit_pkg::SCALE_W-1:0] norm_scale,
    input  logic                                 norm_sign,
    input  logic                                 norm_sticky,
    input  logic                                 norm_zero,
    input  logic                                 norm_nar,
    output logic [posit_pkg::NBITS-1:0]          result,
    output logic                                 done,
    output logic                                 zero,
    output logic                                 inf
);
    import posit_pkg::*;

    localparam int BODY_W = NBITS - 1;  // Word without sign

    logic                      neg;       // Negative scale, regime of zeros
    logic signed [SCALE_W-1:0] regime;
    logic [SCALE_W-1:0]        run;       // Extra regime bits past the first two
    logic [NBITS-1:0]          seed;
    logic [3*NBITS-1:0]        spread;
    logic [BODY_W-1:0]         body;
    logic [BODY_W-1:0]         body_rnd;
    logic [BODY_W-1:0]         mag;
    logic                      round_bit;
    logic                      sticky_bit;
    logic [NBITS-1:0]          packed_word;

    assign neg    = norm_scale[SCALE_W-1];
    assign regime = norm_scale >>> ES;
    assign run    = neg ? ~regime : regime;  // k for k >= 0, -k-1 otherwise

    // Shortest regime, then exponent and fraction without the hidden bit
    assign seed = {~neg, neg, norm_scale[ES-1:0], norm_frac[FRAC_W:0]};

    // Regime fill comes from the top copies as the word moves right
    assign spread = {{NBITS{~neg}}, seed, {NBITS{1'b0}}} >> run;

    assign body       = spread[2*NBITS-1 -: BODY_W];
    assign round_bit  = spread[NBITS];
    assign sticky_bit = (|spread[NBITS-1:0]) | norm_sticky;

    // Ties go to the even word
    assign body_rnd = body + BODY_W'(round_bit & (sticky_bit | body[0]));

    // Clamp to maxpos or minpos rather than reaching NaR or zero
    always_comb
    begin
        if (norm_scale >= MAX_SCALE)
            mag = '1;
        else if (norm_scale < -MAX_SCALE)
            mag = BODY_W'(1);
        else
            mag = body_rnd;
    end

    always_comb
    begin
        if (norm_nar)
            packed_word = {1'b1, {BODY_W{1'b0}}};
        else if (norm_zero)
            packed_word = '0;
        else if (norm_sign)
            packed_word = -{1'b0, mag};  // Two's complement of the whole word
        else
            packed_word = {1'b0, mag};
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            done   <= 1'b0;
            result <= '0;
            zero   <= 1'b1;
            inf    <= 1'b0;
        end
        else
        begin
            done <= norm_valid;
            if (norm_valid)  // Outputs hold between sums
            begin
                result <= packed_word;
                zero   <= norm_zero & ~norm_nar;
                inf    <= norm_nar;
            end
        end
    end

endmodule

//--- list.f
+incdir+testbench
hdl/posit_pkg.sv
hdl/posit_decode.sv
hdl/posit_align_add.sv
hdl/posit_normalize.sv
hdl/posit_round_pack.sv
hdl/posit_accum.sv
testbench/posit_accum_chk.sv
testbench/tb_posit_accum.sv

//--- testbench/posit_accum_chk.sv
// Concurrent checks on strobe timing, start spacing and flags of the accumulator
// Bound into posit_accum at the end of this file
`timescale 1ns/10ps

module posit_accum_chk
(
    input logic                        clk,
    input logic                        rst,
    input logic                        start,
    input logic [posit_pkg::NBITS-1:0] in_word,
    input logic [posit_pkg::NBITS-1:0] result,
    input logic                        done,
    input logic                        zero,
    input logic                        inf
);
    import posit_pkg::*;

    logic [START_GAP-2:0] start_hist;  // Starts seen at the last few edges
    add_op_e              op_q;
    logic                 sign_q;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            start_hist <= '0;
        else
            start_hist <= {start_hist[START_GAP-3:0], start};
    end

    // Result still holds the running sum when a start comes
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            op_q   <= (in_word[NBITS-1] == result[NBITS-1]) ? OP_ADD : OP_SUB;
            sign_q <= in_word[NBITS-1];
        end
    end

    // Done rises at edge k+LATENCY, so it is first sampled high one edge later
    a_done_after_start: assert property (@(posedge clk) disable iff (rst)
        done |-> $past(start, LATENCY + 1)) else $error("done without a matching start");
    a_start_gives_done: assert property (@(posedge clk) disable iff (rst)
        $past(start, LATENCY + 1) |-> done) else $error("start not followed by done");
    a_start_gap: assert property (@(posedge clk) disable iff (rst)
        start |-> start_hist == '0) else $error("starts closer than the minimum gap");
    a_flags_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(zero && inf)) else $error("zero and inf high together");
    a_nar_sticky: assert property (@(posedge clk) disable iff (rst)
        $past(inf) |-> inf) else $error("inf dropped without reset");
    a_add_keeps_sign: assert property (@(posedge clk) disable iff (rst)
        done && op_q == OP_ADD && !zero && !inf |-> result[NBITS-1] == sign_q)
        else $error("same-sign add changed the sign");

endmodule

bind posit_accum posit_accum_chk i_chk
(
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .in_word (in_word),
    .result  (result),
    .done    (done),
    .zero    (zero),
    .inf     (inf)
);

//--- testbench/posit_model.svh
// Reference functions for posit<32,2>: word to real and real to word with RNE
// Included inside the accumulator testbench module

`ifndef POSIT_MODEL_SVH
`define POSIT_MODEL_SVH

// Exact power of two for the scales in use
function automatic real pow2(input int e);
    real r;
    r = 1.0;
    if (e >= 0)
        repeat (e) r = r * 2.0;
    else
        repeat (-e) r = r / 2.0;
    return r;
endfunction

// Value of a posit word; zero and NaR both come back as 0.0
function automatic real posit_to_real(input logic [31:0] w);
    logic [31:0] mag;
    logic [30:0] body;
    logic [30:0] rest;
    int          run;
    int          k;
    real         v;
    if (w == 32'h0 || w == 32'h8000_0000)
        return 0.0;
    mag  = w[31] ? -w : w;
    body = mag[30:0];
    run  = 0;
    while (run < 31 && body[30-run] == body[30])
        run++;
    k    = body[30] ? run - 1 : -run;
    rest = (run >= 30) ? 31'h0 : body << (run + 1);  // Exponent then fraction
    v    = (1.0 + real'(rest[28:0]) / pow2(29)) * pow2(4 * k + int'(rest[30:29]));
    return w[31] ? -v : v;
endfunction

// Nearest posit, ties to the even word, clamped to minpos and maxpos
function automatic logic [31:0] real_to_posit(input real v);
    real          m;
    real          f;
    int           e;
    int           k;
    int           ex;
    int           pos;
    logic [127:0] bits;
    logic [30:0]  body;
    logic [31:0]  w;
    if (v == 0.0)
        return 32'h0;
    m = (v < 0.0) ? -v : v;
    e = 0;
    while (m >= 2.0)
    begin
        m = m / 2.0;
        e++;
    end
    while (m < 1.0)
    begin
        m = m * 2.0;
        e--;
    end
    if (e >= 120)
        body = '1;
    else if (e < -120)
        body = 31'd1;
    else
    begin
        k    = e >>> 2;
        ex   = e - 4 * k;
        bits = '0;
        pos  = 127;
        if (k >= 0)
        begin
            repeat (k + 1)
            begin
                bits[pos] = 1'b1;
                pos--;
            end
            pos--;  // Terminating zero
        end
        else
        begin
            pos       = pos + k;
            bits[pos] = 1'b1;
            pos--;
        end
        bits[pos]     = ex[1];
        bits[pos - 1] = ex[0];
        pos           = pos - 2;
        f = m - 1.0;
        repeat (60)
        begin
            f = f * 2.0;
            if (f >= 1.0)
            begin
                bits[pos] = 1'b1;
                f = f - 1.0;
            end
            pos--;
        end
        body = bits[127:97];
        body = body + {30'd0, bits[96] & ((|bits[95:0]) | body[0])};
    end
    w = {1'b0, body};
    return (v < 0.0) ? -w : w;
endfunction

`endif

//--- testbench/tb_posit_accum.sv
// Random and directed stimulus for the posit accumulator, checked against a real model
// Prints one line per test, the check counts and the final verdict
`timescale 1ns/10ps

module tb_posit_accum;
    import posit_pkg::*;
    `include "posit_model.svh"

    localparam logic [NBITS-1:0] NAR = 32'h8000_0000;
    localparam int N_POS        = 20;
    localparam int N_MIX        = 20;
    localparam int N_ROUND      = 6;
    localparam int N_RANGE      = 15;
    localparam int N_NAR        = 3;
    localparam int TOTAL_STARTS = N_POS + N_MIX + 1 + N_ROUND + N_RANGE + N_NAR;
    localparam int CYCLE_LIMIT  = TOTAL_STARTS * 10 + 100;

    logic             clk     = 1'b0;
    logic             rst     = 1'b1;
    logic             start   = 1'b0;
    logic [NBITS-1:0] in_word = '0;
    logic [NBITS-1:0] result;
    logic             done, zero, inf;

    integer           seed      = 32'h790a4c03;
    logic [NBITS-1:0] acc_model = '0;  // Running sum as the model sees it
    logic             nar_model = 1'b0;
    logic [NBITS-1:0] exp_q[$];
    int               due_q[$];      // Negedge index where done is expected
    int               negs = 0;
    int               cycles = 0;
    int               pass_count = 0;
    int               fail_count = 0;
    int               pass_mark, fail_mark;

    always #5 clk = ~clk;

    posit_accum i_posit_accum
    (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .in_word (in_word),
        .result  (result),
        .done    (done),
        .zero    (zero),
        .inf     (inf)
    );

    task automatic check_value(input string name, input logic [NBITS-1:0] expected,
                               input logic [NBITS-1:0] actual);
        assert (actual === expected) pass_count = pass_count + 1;
        else
        begin
            $display("FAIL t=%0t %s expected %0h got %0h", $time, name, expected, actual);
            fail_count = fail_count + 1;
        end
    endtask

    task automatic finish_run(input bit timed_out);
        $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && !timed_out)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    endtask

    task automatic open_test();
        pass_mark = pass_count;
        fail_mark = fail_count;
    endtask

    // Waits for the last done of the test, then reports it
    task automatic close_test(input string name);
        while (exp_q.size() != 0)
            @(posedge clk);
        $display("%s: %0d checks, %0d failed", name,
                 pass_count - pass_mark + fail_count - fail_mark, fail_count - fail_mark);
    endtask

    // Called right after a rising edge; returns gap edges after the start is sampled
    task automatic send_word(input logic [NBITS-1:0] w);
        logic [NBITS-1:0] expected;
        int               gap;
        if (nar_model || w == NAR)
        begin
            expected  = NAR;
            nar_model = 1'b1;
        end
        else
            expected = real_to_posit(posit_to_real(acc_model) + posit_to_real(w));
        acc_model = expected;
        exp_q.push_back(expected);
        gap = START_GAP + ($unsigned($random(seed)) % 4);
        start   <= 1'b1;
        in_word <= w;
        @(posedge clk);
        start <= 1'b0;
        repeat (gap - 1) @(posedge clk);
    endtask

    task automatic send_real(input real v);
        send_word(real_to_posit(v));
    endtask

    // Scale kept within +-8 so the model sum stays exact in double
    function automatic logic [NBITS-1:0] random_word(input bit mixed);
        int          sc;
        logic [26:0] frac;
        real         v;
        sc   = $unsigned($random(seed)) % 17;
        sc   = sc - 8;
        frac = 27'($random(seed));
        v    = (1.0 + real'(frac) / pow2(27)) * pow2(sc);
        if (mixed && (($random(seed) & 1) != 0))
            v = -v;
        return real_to_posit(v);
    endfunction

    // Matches each done against the oldest pending start
    always @(negedge clk)
    begin : monitor
        int               due;
        logic [NBITS-1:0] exp_w;
        if (!rst)
        begin
            if (start)
                due_q.push_back(negs + LATENCY + 1);
            if (done)
            begin
                assert (due_q.size() != 0)
                else
                begin
                    $display("ERROR t=%0t done pulsed with no start pending", $time);
                    fail_count = fail_count + 1;
                end
                if (due_q.size() != 0)
                begin
                    due   = due_q.pop_front();
                    exp_w = exp_q.pop_front();
                    assert (negs == due)
                    else
                    begin
                        $display("ERROR t=%0t done came %0d cycles off its slot", $time,
                                 negs - due);
                        fail_count = fail_count + 1;
                    end
                    check_value("result", exp_w, result);
                    check_value("zero", exp_w == '0, zero);
                    check_value("inf", exp_w == NAR, inf);
                end
            end
            else if (due_q.size() != 0 && negs > due_q[0])
            begin
                $display("ERROR t=%0t done never came for a start", $time);
                fail_count = fail_count + 1;
                due = due_q.pop_front();
                exp_w = exp_q.pop_front();
            end
        end
        negs = negs + 1;
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT)
        begin
            $display("ERROR run did not finish within %0d cycles", CYCLE_LIMIT);
            finish_run(1'b1);
        end
    end

    initial
    begin
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        open_test();
        repeat (6)
        begin
            @(negedge clk);
            check_value("done", '0, done);
            check_value("result", '0, result);
            check_value("zero", 1, zero);
            check_value("inf", '0, inf);
        end
        close_test("Idle after reset");
        @(posedge clk);

        open_test();
        repeat (N_POS) send_word(random_word(1'b0));
        close_test("Random positive sums");

        open_test();
        repeat (N_MIX) send_word(random_word(1'b1));
        send_word(-acc_model);  // Exact cancellation
        close_test("Mixed signs and cancellation");

        open_test();
        send_real(1.0);
        send_real(pow2(-28));               // Tie, stays even
        send_real(3.0 * pow2(-28));         // Tie on an odd word, rounds up
        send_real(pow2(-28) + pow2(-40));   // Above the tie by sticky
        send_real(-pow2(-28));
        send_word(-acc_model);
        close_test("Round to nearest even");

        open_test();
        send_real(pow2(120));
        send_real(pow2(120));               // Clamps at maxpos
        send_real(pow2(-40));
        send_real(-pow2(120));
        send_real(-pow2(120));
        send_real(-pow2(120));              // Clamps at negative maxpos
        send_real(pow2(120));
        send_real(pow2(40));
        send_real(pow2(-40));               // Lost below the last bit
        send_real(pow2(22));                // Exact half, stays even
        send_real(pow2(22) + 1.0);          // Half plus sticky, rounds up
        send_word(-acc_model);
        send_real(pow2(-120));
        send_real(pow2(-120));
        send_real(-pow2(-120));
        close_test("Large and small magnitudes");

        open_test();
        send_word(NAR);
        repeat (N_NAR - 1) send_word(random_word(1'b1));
        close_test("NaR input");

        finish_run(1'b0);
    end

endmodule
